//--- hdl/island_cfg_pkg.sv
// Memory island configuration
`default_nettype none

package island_cfg_pkg;

    // ----------------------------------------
    // Address and data geometry
    // ----------------------------------------

    // Byte address seen by both ports
    localparam int unsigned addr_width = 12;

    // One memory word
    localparam int unsigned data_width = 32;

    // One enable per byte lane
    localparam int unsigned be_width = data_width / 8;

    // Byte offset inside a word, dropped before bank selection
    localparam int unsigned word_lsb = $clog2(be_width);

    // Bank select and row index are taken from the bits above word_lsb
    // Low word bits pick the bank so consecutive words interleave

endpackage

`default_nettype wire

//--- hdl/mem_proto_pkg.sv
// Bus and memory protocol types
`default_nettype none

package mem_proto_pkg;

    // ----------------------------------------
    // Bus side
    // ----------------------------------------

    // Command held by the master for as long as req is high
    typedef struct packed {
        logic                                 write;
        logic [island_cfg_pkg::addr_width-1:0] addr;
        logic [island_cfg_pkg::data_width-1:0] wdata;
        logic [island_cfg_pkg::be_width-1:0]   be;
    } bus_cmd_t;

    // ----------------------------------------
    // Memory protocol
    // ----------------------------------------

    // Request, taken when valid and gnt are both high
    typedef struct packed {
        logic                                 valid;
        logic                                 write;
        logic [island_cfg_pkg::addr_width-1:0] addr;
        logic [island_cfg_pkg::data_width-1:0] wdata;
        logic [island_cfg_pkg::be_width-1:0]   be;
    } mem_req_t;

    // Response, one per granted request, never stalled
    typedef struct packed {
        logic                                 valid;
        logic [island_cfg_pkg::data_width-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/bank_sram.sv
// Byte-enabled SRAM bank
`default_nettype none
`timescale 1ns/1ps

module bank_sram #(
    parameter int unsigned bank_words = 256
) (
    input  logic                                  clk_i,
    input  logic                                  en_i,
    input  logic                                  we_i,
    input  logic [$clog2(bank_words)-1:0]         addr_i,
    input  logic [island_cfg_pkg::data_width-1:0] wdata_i,
    input  logic [island_cfg_pkg::be_width-1:0]   be_i,
    output logic [island_cfg_pkg::data_width-1:0] rdata_o
);
    import island_cfg_pkg::*;

    // Bits per byte lane
    localparam int unsigned lane_bits = data_width / be_width;

    // Word-addressed storage
    logic [data_width-1:0] mem_q [bank_words];

    // ----------------------------------------
    // Single port, one access per cycle
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                // Only enabled lanes change
                for (int b = 0; b < be_width; b++) begin
                    if (be_i[b]) begin
                        mem_q[addr_i][b*lane_bits +: lane_bits] <= wdata_i[b*lane_bits +: lane_bits];
                    end
                end
            end
            // Read-before-write on a write access, the port ignores it
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/bus_to_mem_adapter.sv
// Four-phase bus adapter
`default_nettype none
`timescale 1ns/1ps

module bus_to_mem_adapter (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  req_i,
    input  mem_proto_pkg::bus_cmd_t               bus_cmd_i,
    output logic                                  ack_o,
    output logic [island_cfg_pkg::data_width-1:0] bus_rdata_o,
    output mem_proto_pkg::mem_req_t               mem_req_o,
    input  logic                                  mem_gnt_i,
    input  mem_proto_pkg::mem_rsp_t               mem_rsp_i
);
    import island_cfg_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_wait_rsp,
        st_ack,
        st_wait_rel
    } state_e;

    state_e state_q, state_d;
    logic issue;
    logic [data_width-1:0] rdata_q;

    // ----------------------------------------
    // Request side
    // ----------------------------------------

    // Request goes out in the same cycle req_i is first seen
    assign issue = ((state_q == st_idle) && req_i) || (state_q == st_issue);

    // Bus command is stable while req_i is high, so it feeds the request directly
    assign mem_req_o = '{valid: issue,
                         write: bus_cmd_i.write,
                         addr:  bus_cmd_i.addr,
                         wdata: bus_cmd_i.wdata,
                         be:    bus_cmd_i.be};

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle:     if (req_i) state_d = mem_gnt_i ? st_wait_rsp : st_issue;
            // Hold until the cut or the core takes it
            st_issue:    if (mem_gnt_i) state_d = st_wait_rsp;
            st_wait_rsp: if (mem_rsp_i.valid) state_d = st_ack;
            // First ack cycle, master may already release
            st_ack:      state_d = req_i ? st_wait_rel : st_idle;
            st_wait_rel: if (!req_i) state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Read data captured once, shown while ack is high
    always_ff @(posedge clk_i) begin
        if ((state_q == st_wait_rsp) && mem_rsp_i.valid) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    assign ack_o       = (state_q == st_ack) || (state_q == st_wait_rel);
    assign bus_rdata_o = rdata_q;

    // Only one access outstanding, so a response can only land while waiting for it
    a_rsp_only_when_waiting: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_rsp_i.valid |-> (state_q == st_wait_rsp));

    // Four-phase rule seen from the master side
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

//--- hdl/mem_cut.sv
// Memory protocol pipeline cuts
`default_nettype none
`timescale 1ns/1ps

module mem_cut #(
    parameter int unsigned num_req_cuts = 1,
    parameter int unsigned num_rsp_cuts = 1
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  mem_proto_pkg::mem_req_t req_i,
    output logic                    gnt_o,
    output mem_proto_pkg::mem_req_t req_o,
    input  logic                    gnt_i,
    input  mem_proto_pkg::mem_rsp_t rsp_i,
    output mem_proto_pkg::mem_rsp_t rsp_o
);
    import island_cfg_pkg::*;
    import mem_proto_pkg::*;

    // Index 0 faces the requester, the last index faces the core
    mem_req_t req_chain [num_req_cuts+1];
    logic     gnt_chain [num_req_cuts+1];
    mem_rsp_t rsp_chain [num_rsp_cuts+1];

    assign req_chain[0]            = req_i;
    assign gnt_o                   = gnt_chain[0];
    assign req_o                   = req_chain[num_req_cuts];
    assign gnt_chain[num_req_cuts] = gnt_i;

    // ----------------------------------------
    // Request stages with back-pressure
    // ----------------------------------------
    for (genvar k = 0; k < num_req_cuts; k++) begin : g_req_stage
        logic     valid_q;
        mem_req_t data_q;

        // Empty stage or one draining this cycle can take a new entry
        assign gnt_chain[k] = !valid_q || gnt_chain[k+1];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                valid_q <= 1'b0;
            end else if (gnt_chain[k]) begin
                valid_q <= req_chain[k].valid;
            end
        end

        always_ff @(posedge clk_i) begin
            if (gnt_chain[k]) begin
                data_q <= req_chain[k];
            end
        end

        assign req_chain[k+1] = '{valid: valid_q,
                                  write: data_q.write,
                                  addr:  data_q.addr,
                                  wdata: data_q.wdata,
                                  be:    data_q.be};

        // A stalled entry stays put until downstream takes it
        a_no_overwrite: assert property (@(posedge clk_i) disable iff (rst_i)
            (valid_q && !gnt_chain[k+1]) |=> (valid_q && $stable(data_q)));
    end

    // ----------------------------------------
    // Response stages, no stall
    // ----------------------------------------
    assign rsp_chain[0] = rsp_i;
    assign rsp_o        = rsp_chain[num_rsp_cuts];

    for (genvar k = 0; k < num_rsp_cuts; k++) begin : g_rsp_stage
        logic                  valid_q;
        logic [data_width-1:0] rdata_q;

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= rsp_chain[k].valid;
            end
        end

        always_ff @(posedge clk_i) begin
            rdata_q <= rsp_chain[k].rdata;
        end

        assign rsp_chain[k+1] = '{valid: valid_q, rdata: rdata_q};
    end

endmodule

`default_nettype wire

//--- hdl/island_core.sv
// Banked memory island core
`default_nettype none
`timescale 1ns/1ps

module island_core #(
    parameter int unsigned num_banks  = 4,
    parameter int unsigned bank_words = 256
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  mem_proto_pkg::mem_req_t bus_req_i,
    output logic                    bus_gnt_o,
    output mem_proto_pkg::mem_rsp_t bus_rsp_o,
    input  mem_proto_pkg::mem_req_t dir_req_i,
    output logic                    dir_gnt_o,
    output mem_proto_pkg::mem_rsp_t dir_rsp_o
);
    import island_cfg_pkg::*;

    localparam int unsigned bank_bits = $clog2(num_banks);
    localparam int unsigned idx_bits  = $clog2(bank_words);

    logic [bank_bits-1:0]  bus_bank, dir_bank;
    logic [idx_bits-1:0]   bus_idx, dir_idx;
    logic                  conflict;
    // Per bank, set means the direct port wins the next clash
    logic [num_banks-1:0]  prio_q;
    logic                  bus_rsp_valid_q, dir_rsp_valid_q;
    logic [bank_bits-1:0]  bus_bank_q, dir_bank_q;
    logic [data_width-1:0] bank_rdata [num_banks];

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    // Low word bits select the bank, the bits above select the row
    assign bus_bank = bus_req_i.addr[word_lsb +: bank_bits];
    assign dir_bank = dir_req_i.addr[word_lsb +: bank_bits];
    assign bus_idx  = bus_req_i.addr[word_lsb + bank_bits +: idx_bits];
    assign dir_idx  = dir_req_i.addr[word_lsb + bank_bits +: idx_bits];

    // ----------------------------------------
    // Arbitration
    // ----------------------------------------
    assign conflict  = bus_req_i.valid && dir_req_i.valid && (bus_bank == dir_bank);
    assign bus_gnt_o = bus_req_i.valid && !(conflict && prio_q[bus_bank]);
    assign dir_gnt_o = dir_req_i.valid && !(conflict && !prio_q[dir_bank]);

    // Loser of a clash wins the next one on that bank
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_q <= '0;
        end else if (conflict) begin
            prio_q[bus_bank] <= !prio_q[bus_bank];
        end
    end

    // ----------------------------------------
    // Bank array
    // ----------------------------------------
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        logic bus_hit, dir_hit;

        assign bus_hit = bus_gnt_o && (bus_bank == bank_bits'(b));
        assign dir_hit = dir_gnt_o && (dir_bank == bank_bits'(b));

        // At most one hit per bank, the winner drives it
        bank_sram #(
            .bank_words(bank_words)
        ) u_bank (
            .clk_i  (clk_i),
            .en_i   (bus_hit || dir_hit),
            .we_i   (dir_hit ? dir_req_i.write : bus_req_i.write),
            .addr_i (dir_hit ? dir_idx : bus_idx),
            .wdata_i(dir_hit ? dir_req_i.wdata : bus_req_i.wdata),
            .be_i   (dir_hit ? dir_req_i.be : bus_req_i.be),
            .rdata_o(bank_rdata[b])
        );
    end

    // ----------------------------------------
    // Response routing
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_rsp_valid_q <= 1'b0;
            dir_rsp_valid_q <= 1'b0;
        end else begin
            bus_rsp_valid_q <= bus_gnt_o;
            dir_rsp_valid_q <= dir_gnt_o;
        end
    end

    // Bank used by each port, needed when its read data comes out
    always_ff @(posedge clk_i) begin
        bus_bank_q <= bus_bank;
        dir_bank_q <= dir_bank;
    end

    assign bus_rsp_o = '{valid: bus_rsp_valid_q, rdata: bank_rdata[bus_bank_q]};
    assign dir_rsp_o = '{valid: dir_rsp_valid_q, rdata: bank_rdata[dir_bank_q]};

    a_no_shared_bank: assert property (@(posedge clk_i) disable iff (rst_i)
        !(bus_gnt_o && dir_gnt_o && (bus_bank == dir_bank)));

    // Fixed one-cycle response latency on both ports
    a_rsp_follows_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_rsp_o.valid == ($past(bus_gnt_o) && !$past(rst_i))) &&
        (dir_rsp_o.valid == ($past(dir_gnt_o) && !$past(rst_i))));

endmodule

`default_nettype wire

//--- hdl/island_wrap.sv
// Memory island top level
`default_nettype none
`timescale 1ns/1ps

module island_wrap #(
    parameter int unsigned num_banks    = 4,
    parameter int unsigned bank_words   = 256,
    parameter int unsigned num_req_cuts = 1,
    parameter int unsigned num_rsp_cuts = 1
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    // Four-phase bus port
    input  logic                                  req_i,
    input  mem_proto_pkg::bus_cmd_t               bus_cmd_i,
    output logic                                  ack_o,
    output logic [island_cfg_pkg::data_width-1:0] bus_rdata_o,
    // Direct memory port
    input  mem_proto_pkg::mem_req_t               mem_req_i,
    output logic                                  mem_gnt_o,
    output mem_proto_pkg::mem_rsp_t               mem_rsp_o
);
    import mem_proto_pkg::*;

    // Adapter side of the entry cut
    mem_req_t adp_req;
    logic     adp_gnt;
    mem_rsp_t adp_rsp;

    // Core side of the entry cut
    mem_req_t core_req;
    logic     core_gnt;
    mem_rsp_t core_rsp;

    // ----------------------------------------
    // Bus adapter
    // ----------------------------------------
    bus_to_mem_adapter u_adapter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .bus_cmd_i  (bus_cmd_i),
        .ack_o      (ack_o),
        .bus_rdata_o(bus_rdata_o),
        .mem_req_o  (adp_req),
        .mem_gnt_i  (adp_gnt),
        .mem_rsp_i  (adp_rsp)
    );

    // ----------------------------------------
    // Entry cut, bus path only
    // ----------------------------------------
    mem_cut #(
        .num_req_cuts(num_req_cuts),
        .num_rsp_cuts(num_rsp_cuts)
    ) u_entry_cut (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .req_i(adp_req),
        .gnt_o(adp_gnt),
        .req_o(core_req),
        .gnt_i(core_gnt),
        .rsp_i(core_rsp),
        .rsp_o(adp_rsp)
    );

    // ----------------------------------------
    // Core, direct port wired straight in
    // ----------------------------------------
    island_core #(
        .num_banks (num_banks),
        .bank_words(bank_words)
    ) u_core (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .bus_req_i(core_req),
        .bus_gnt_o(core_gnt),
        .bus_rsp_o(core_rsp),
        .dir_req_i(mem_req_i),
        .dir_gnt_o(mem_gnt_o),
        .dir_rsp_o(mem_rsp_o)
    );

endmodule

`default_nettype wire

//--- verification/island_wrap_tb.sv
// Memory island testbench
`default_nettype none
`timescale 1ns/1ps

module island_wrap_tb;
    import island_cfg_pkg::*;
    import mem_proto_pkg::*;

    // Words behind the byte address space
    localparam int num_words = 1 << (addr_width - word_lsb);
    // Adapter issue, request cut, core, response cut
    localparam int bus_latency = 4;
    // Fill, bus pairs, direct mix, contention, cross-port
    localparam int num_txn = 1024 + 32 + 64 + 56 + 32;
    localparam int max_cycles = num_txn * 20;

    logic                  clk_i;
    logic                  rst_i;
    logic                  req_i;
    bus_cmd_t              bus_cmd_i;
    logic                  ack_o;
    logic [data_width-1:0] bus_rdata_o;
    mem_req_t              mem_req_i;
    logic                  mem_gnt_o;
    mem_rsp_t              mem_rsp_o;

    // Reference model state
    logic [data_width-1:0] ref_mem [num_words];
    logic [data_width-1:0] bus_exp;
    logic [data_width-1:0] dir_ref_word;
    logic [31:0]           rng = 32'h64c9;
    logic                  stim_on = 1'b0;
    // Low while direct traffic may hit the core
    logic                  bus_solo = 1'b1;
    int                    cycle_cnt = 0;

    island_wrap dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .bus_cmd_i  (bus_cmd_i),
        .ack_o      (ack_o),
        .bus_rdata_o(bus_rdata_o),
        .mem_req_i  (mem_req_i),
        .mem_gnt_o  (mem_gnt_o),
        .mem_rsp_o  (mem_rsp_o)
    );

    always #10 clk_i = ~clk_i;

    // Word the direct port should read in this cycle
    assign dir_ref_word = ref_mem[mem_req_i.addr[addr_width-1:word_lsb]];

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Byte-lane write onto the old word
    function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_word,
                                                          input logic [data_width-1:0] wdata,
                                                          input logic [be_width-1:0] be);
        logic [data_width-1:0] res;
        res = old_word;
        for (int b = 0; b < be_width; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_failure(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "check failed");
    endtask

    // One four-phase transfer, returns with ack low again
    task automatic bus_access(input logic wr, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata, input logic [be_width-1:0] be);
        bus_exp   = ref_mem[addr[addr_width-1:word_lsb]];
        bus_cmd_i = '{write: wr, addr: addr, wdata: wdata, be: be};
        req_i     = 1'b1;
        do begin
            @(posedge clk_i);
            #1;
        end while (!ack_o);
        if (wr) begin
            ref_mem[addr[addr_width-1:word_lsb]] = merge_bytes(bus_exp, wdata, be);
        end
        req_i = 1'b0;
        do begin
            @(posedge clk_i);
            #1;
        end while (ack_o);
    endtask

    // Request stays driven on return so calls can run back to back
    task automatic dir_access(input logic wr, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata, input logic [be_width-1:0] be);
        mem_req_i = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata, be: be};
        @(negedge clk_i);
        // Held until the core grants it
        while (!mem_gnt_o) begin
            @(negedge clk_i);
        end
        if (wr) begin
            ref_mem[addr[addr_width-1:word_lsb]] =
                merge_bytes(ref_mem[addr[addr_width-1:word_lsb]], wdata, be);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic dir_release();
        mem_req_i.valid = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
        !stim_on |-> (!ack_o && !mem_gnt_o && !mem_rsp_o.valid))
        else report_failure("output active before stimulus");

    a_bus_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_o && !bus_cmd_i.write) |-> (bus_rdata_o == bus_exp))
        else report_failure("bus read data differs from reference");

    a_ack_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i))
        else report_failure("ack rose without req");

    a_ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_o && !req_i) |=> !ack_o)
        else report_failure("ack did not fall after req fell");

    a_bus_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_solo && $rose(req_i)) |-> ##bus_latency $rose(ack_o))
        else report_failure("uncontended bus latency wrong");

    a_dir_rsp_timing: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_rsp_o.valid == $past(mem_req_i.valid && mem_gnt_o))
        else report_failure("direct response not one cycle after grant");

    a_dir_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && mem_gnt_o && !mem_req_i.write) |=>
            (mem_rsp_o.rdata == $past(dir_ref_word)))
        else report_failure("direct read data differs from reference");

    // Round robin gives the direct port the next clash
    a_no_double_refusal: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && !mem_gnt_o) |=> !(mem_req_i.valid && !mem_gnt_o))
        else report_failure("direct port refused twice in a row");

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > max_cycles) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycle_cnt);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0]           r;
        logic [addr_width-1:0] addr_list [16];
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        req_i     = 1'b0;
        bus_cmd_i = '0;
        mem_req_i = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // Idle window for the post-reset check
        repeat (5) @(posedge clk_i);
        #1;
        stim_on = 1'b1;

        // Fill every word through the direct port
        for (int i = 0; i < num_words; i++) begin
            dir_access(1'b1, addr_width'(i << word_lsb), next_rand(), '1);
        end
        dir_release();

        // Bus writes with random lanes, then reads of the same words
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            addr_list[i] = {r[9:0], 2'b00};
            bus_access(1'b1, addr_list[i], next_rand(), r[15:12]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_access(1'b0, addr_list[i], '0, '1);
        end

        // Direct mix, one per cycle with several in flight
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            dir_access(r[0], {r[11:2], 2'b00}, next_rand(), r[15:12]);
        end
        dir_release();

        // Both ports on bank 2, bus in the lower rows, direct in the upper rows
        bus_solo = 1'b0;
        fork
            for (int i = 0; i < 8; i++) begin
                r = next_rand();
                bus_access(r[8], {1'b0, r[6:0], 2'b10, 2'b00}, next_rand(), r[15:12]);
            end
            begin
                for (int i = 0; i < 48; i++) begin
                    r = next_rand();
                    dir_access(r[8], {1'b1, r[6:0], 2'b10, 2'b00}, next_rand(), r[15:12]);
                end
                dir_release();
            end
        join
        bus_solo = 1'b1;

        // Cross-port, bank cycles with the index
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            addr_list[i] = {r[7:0], i[1:0], 2'b00};
            bus_access(1'b1, addr_list[i], next_rand(), r[15:12]);
        end
        for (int i = 0; i < 8; i++) begin
            dir_access(1'b0, addr_list[i], '0, '1);
        end
        dir_release();
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            addr_list[i] = {r[7:0], i[1:0], 2'b00};
            dir_access(1'b1, addr_list[i], next_rand(), r[15:12]);
        end
        dir_release();
        for (int i = 0; i < 8; i++) begin
            bus_access(1'b0, addr_list[i], '0, '1);
        end

        repeat (5) @(posedge clk_i);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/island_cfg_pkg.sv
hdl/mem_proto_pkg.sv
hdl/bank_sram.sv
hdl/bus_to_mem_adapter.sv
hdl/mem_cut.sv
hdl/island_core.sv
hdl/island_wrap.sv
verification/island_wrap_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := island_wrap_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
